/* bench/alu_tb.sv */
module alu_tb
    import alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Bound on every wait, in transfers or clock cycles
    localparam int poll_limit = 50;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        xfer_done;

    // Expected bus responses, set up by the stimulus before each transfer
    logic        exp_err;
    logic        check_result;
    logic        expect_none;
    logic        expect_stall;
    logic [8:0]  exp_res;
    logic [31:0] exp_status;
    logic [8:0]  exp_q[$];
    int          error_count;
    int          timeout_count;
    integer      seed;

    always #4 clk = ~clk;

    alu_top #(
        .fifo_depth (4)
    ) dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // A transfer completes on the edge where all three are high
    assign xfer_done = psel && penable && pready;

    task automatic flag_mismatch(input string msg);
        error_count++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // A valid result must be the oldest outstanding command's model value
    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        (xfer_done && !pwrite && paddr == REG_RESULT && prdata[16])
        |-> (check_result && prdata == {15'h0000, 1'b1, 7'h00, exp_res}))
        else flag_mismatch("RESULT read differs from the ALU model");
    a_no_result: assert property (@(posedge clk) disable iff (!arst_n)
        (xfer_done && !pwrite && paddr == REG_RESULT && expect_none) |-> prdata == 32'h0)
        else flag_mismatch("RESULT read shows data with nothing pending");
    a_status: assert property (@(posedge clk) disable iff (!arst_n)
        (xfer_done && !pwrite && paddr == REG_STATUS) |-> prdata == exp_status)
        else flag_mismatch("STATUS read differs from the expected level and flags");
    // Anything other than RESULT and STATUS reads back as zero
    a_unknown_read: assert property (@(posedge clk) disable iff (!arst_n)
        (xfer_done && !pwrite && paddr != REG_RESULT && paddr != REG_STATUS)
        |-> prdata == 32'h0)
        else flag_mismatch("read of an unknown address is not zero");
    a_slverr: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_done |-> pslverr == exp_err)
        else flag_mismatch("pslverr differs from the expected value");
    // Wait states appear only when a command meets a full queue
    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && expect_stall) |-> !pready)
        else flag_mismatch("write to a full queue was not held off");
    a_no_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && !expect_stall) |-> pready)
        else flag_mismatch("unexpected wait state on the bus");

    // ALU rules on the effective operands, arithmetic in 9 bits with active-low carries
    function automatic logic [8:0] model_alu(input logic [4:0] op, input logic [7:0] x,
                                             input logic [7:0] y, input logic cin_n);
        logic [8:0]  s;
        logic [8:0]  c;
        logic [15:0] p;
        c = {8'h00, !cin_n};
        p = {8'h00, x} * {8'h00, y};
        s = 9'h000;
        case (op)
            OP_A:       return {1'b1, x};
            OP_B:       return {1'b1, y};
            OP_ZERO:    return {1'b1, 8'h00};
            OP_AND:     return {1'b1, x & y};
            OP_OR:      return {1'b1, x | y};
            OP_XOR:     return {1'b1, x ^ y};
            OP_NOT_A:   return {1'b1, ~x};
            OP_MUL_HI:  return {1'b1, p[15:8]};
            OP_MUL_LO:  return {1'b1, p[7:0]};
            OP_NEG_A:   s = 9'h000 - {1'b0, x};
            OP_NEG_B:   s = 9'h000 - {1'b0, y};
            OP_A_INC:   s = {1'b0, x} + 9'h001;
            OP_B_INC:   s = {1'b0, y} + 9'h001;
            OP_A_DEC:   s = {1'b0, x} - 9'h001;
            OP_B_DEC:   s = {1'b0, y} - 9'h001;
            OP_A_ADD_B: s = {1'b0, x} + {1'b0, y} + c;
            OP_A_SUB_B: s = {1'b0, x} - {1'b0, y} - c;
            OP_B_SUB_A: s = {1'b0, y} - {1'b0, x} - c;
            default:    return {1'b1, 8'h00};
        endcase
        return {~s[8], s[7:0]};
    endfunction

    // Force controls act first, pass-X then returns the effective X unchanged
    function automatic logic [8:0] expect_cmd(input logic [4:0] op, input logic [7:0] x,
                                              input logic [7:0] y, input logic passx,
                                              input logic xzero, input logic cin_n);
        logic [7:0] xe;
        xe = xzero ? 8'h00 : x;
        if (passx) begin
            return {1'b1, xe};
        end
        return model_alu(op, xe, y, cin_n);
    endfunction

    // One APB transfer, inputs driven 1 ns after the edge and outputs sampled at the falling edge
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            input logic err, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        exp_err = err;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!pready && waited < poll_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            timeout_count++;
            $display("Timeout: APB transfer to address 0x%h never completed", addr);
        end
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic queue_cmd(input logic [4:0] op, input logic [7:0] x, input logic [7:0] y,
                             input logic passx, input logic xzero, input logic cin_n);
        logic [31:0] rd;
        apb_xfer(1'b1, REG_OPERANDS, {16'h0000, y, x}, 1'b0, rd);
        apb_xfer(1'b1, REG_CMD, {21'h0, cin_n, xzero, passx, 3'b000, op}, 1'b0, rd);
        exp_q.push_back(expect_cmd(op, x, y, passx, xzero, cin_n));
    endtask

    // Polls RESULT until the valid bit shows, the assertion checks that read
    task automatic take_result();
        logic [31:0] rd;
        int          polls;
        exp_res      = exp_q.pop_front();
        check_result = 1'b1;
        polls        = 0;
        rd           = 32'h0;
        while (!rd[16] && polls < poll_limit) begin
            apb_xfer(1'b0, REG_RESULT, 32'h0, 1'b0, rd);
            polls++;
        end
        check_result = 1'b0;
        if (!rd[16]) begin
            timeout_count++;
            $display("Timeout: no valid result after %0d polls", polls);
        end
    endtask

    task automatic check_status(input logic [31:0] expected);
        logic [31:0] rd;
        exp_status = expected;
        apb_xfer(1'b0, REG_STATUS, 32'h0, 1'b0, rd);
    endtask

    // Starts a command write into a full queue, watches it stall, then withdraws it
    task automatic hold_stalled_write(input logic [4:0] op, input int cycles);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = REG_CMD;
        pwdata  = {27'h0, op};
        exp_err = 1'b0;
        @(posedge clk);
        #1;
        penable      = 1'b1;
        expect_stall = 1'b1;
        repeat (cycles) @(posedge clk);
        #1;
        psel         = 1'b0;
        penable      = 1'b0;
        expect_stall = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        int          code;
        int          mode;
        logic        cin_n;
        seed          = 32'h6451;
        error_count   = 0;
        timeout_count = 0;
        arst_n        = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = 4'h0;
        pwdata        = 32'h0;
        exp_err       = 1'b0;
        check_result  = 1'b0;
        expect_none   = 1'b0;
        expect_stall  = 1'b0;
        exp_res       = 9'h000;
        exp_status    = 32'h0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // After reset the queue is empty and no result is pending
        check_status(32'h0000_0200);
        expect_none = 1'b1;
        apb_xfer(1'b0, REG_RESULT, 32'h0, 1'b0, rd);
        expect_none = 1'b0;

        // Modes 0 and 1 cover both carry levels, 2 to 4 cover the force controls
        for (code = 0; code < 32; code++) begin
            if (op_implemented(5'(code))) begin
                for (mode = 0; mode < 5; mode++) begin
                    cin_n = (mode < 2) ? 1'(mode) : 1'($random(seed));
                    queue_cmd(5'(code), 8'($random(seed)), 8'($random(seed)),
                              mode >= 3, mode == 2 || mode == 4, cin_n);
                    take_result();
                end
            end
        end

        // Refused commands and unknown addresses leave the queue empty
        for (code = 0; code < 32; code++) begin
            if (!op_implemented(5'(code))) begin
                apb_xfer(1'b1, REG_CMD, 32'(code), 1'b1, rd);
            end
        end
        apb_xfer(1'b0, 4'h2, 32'h0, 1'b1, rd);
        apb_xfer(1'b1, REG_RESULT, 32'h0000_1234, 1'b1, rd);
        check_status(32'h0000_0200);

        // Exec holds one result, so five commands fill the queue and a sixth stalls
        for (code = 0; code < 5; code++) begin
            queue_cmd(OP_A_ADD_B, 8'($random(seed)), 8'(code), 1'b0, 1'b0, 1'b1);
        end
        check_status(32'h0000_0104);
        hold_stalled_write(OP_XOR, 6);
        take_result();
        queue_cmd(OP_XOR, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b1);
        repeat (5) take_result();

        if (exp_q.size() != 0) begin
            error_count++;
            $display("Bench error: %0d expected results were never read back", exp_q.size());
        end
        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* logic/alu.sv */
module alu
    import alu_pkg::*;
(
    input  alu_cmd_t cmd,
    output alu_res_t res
);

    logic [7:0]  x_eff;
    alu_op_e     op_eff;
    logic [8:0]  cin9;
    logic [8:0]  sum9;
    logic [15:0] prod;
    logic [7:0]  logic_o;
    logic        arith;

    // Forcing X to zero replaces the operand before any opcode sees it
    assign x_eff = cmd.force_x_zero ? 8'h00 : cmd.x;

    // Forcing pass-X overrides whatever opcode the command carries
    assign op_eff = cmd.force_passx ? OP_A : cmd.op;

    // Carry in is active low on the interface, so invert it once here
    assign cin9 = {8'h00, ~cmd.cin_n};

    // Both multiply opcodes share one 8x8 product
    assign prod = x_eff * cmd.y;

    always_comb begin
        sum9    = 9'h000;
        logic_o = 8'h00;
        arith   = 1'b0;
        case (op_eff)
            OP_A:     logic_o = x_eff;
            OP_B:     logic_o = cmd.y;
            OP_ZERO:  logic_o = 8'h00;
            OP_AND:   logic_o = x_eff & cmd.y;
            OP_OR:    logic_o = x_eff | cmd.y;
            OP_XOR:   logic_o = x_eff ^ cmd.y;
            OP_NOT_A: logic_o = ~x_eff;
            OP_MUL_HI: logic_o = prod[15:8];
            OP_MUL_LO: logic_o = prod[7:0];
            // Negation is zero minus the operand, so bit 8 flags a nonzero input
            OP_NEG_A: begin
                sum9  = 9'h000 - {1'b0, x_eff};
                arith = 1'b1;
            end
            OP_NEG_B: begin
                sum9  = 9'h000 - {1'b0, cmd.y};
                arith = 1'b1;
            end
            // Increment and decrement step by a fixed one and ignore carry in
            OP_A_INC: begin
                sum9  = {1'b0, x_eff} + 9'h001;
                arith = 1'b1;
            end
            OP_B_INC: begin
                sum9  = {1'b0, cmd.y} + 9'h001;
                arith = 1'b1;
            end
            OP_A_DEC: begin
                sum9  = {1'b0, x_eff} - 9'h001;
                arith = 1'b1;
            end
            OP_B_DEC: begin
                sum9  = {1'b0, cmd.y} - 9'h001;
                arith = 1'b1;
            end
            // Two-operand ops chain the incoming carry for multi-byte arithmetic
            OP_A_ADD_B: begin
                sum9  = {1'b0, x_eff} + {1'b0, cmd.y} + cin9;
                arith = 1'b1;
            end
            OP_A_SUB_B: begin
                sum9  = {1'b0, x_eff} - {1'b0, cmd.y} - cin9;
                arith = 1'b1;
            end
            OP_B_SUB_A: begin
                sum9  = {1'b0, cmd.y} - {1'b0, x_eff} - cin9;
                arith = 1'b1;
            end
            // Unimplemented codes never reach here through the port and give zero
            default:  logic_o = 8'h00;
        endcase
    end

    // Only arithmetic results can raise carry out and everything else reports none
    assign res.o      = arith ? sum9[7:0] : logic_o;
    assign res.cout_n = arith ? ~sum9[8] : 1'b1;

endmodule

/* logic/alu_cmd_fifo.sv */
module alu_cmd_fifo
    import alu_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  alu_cmd_t   push_cmd,
    input  logic       pop,
    output alu_cmd_t   pop_cmd,
    output logic       full,
    output logic       empty,
    output logic [7:0] level
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(fifo_depth - 1);

    alu_cmd_t         mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [7:0]       count;

    // Each push writes its command into the slot at the write pointer
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // Pointers wrap at the last slot so any depth works, not only powers of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 8'd0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            // A push and pop in the same cycle leave the level unchanged
            case ({push, pop})
                2'b10:   count <= count + 8'd1;
                2'b01:   count <= count - 8'd1;
                default: count <= count;
            endcase
        end
    end

    // With first-word fall-through the head entry is on the output while not empty
    assign pop_cmd = mem[rd_ptr];
    assign full    = (count == 8'(fifo_depth));
    assign empty   = (count == 8'd0);
    assign level   = count;

    // The port must hold off while full and exec must wait for data
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

/* logic/alu_cmd_port.sv */
module alu_cmd_port
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        full,
    input  logic        empty,
    input  logic [7:0]  level,
    output logic        push,
    output alu_cmd_t    push_cmd,
    input  logic        res_valid,
    input  alu_res_t    res,
    output logic        res_take
);

    logic [7:0] x_q;
    logic [7:0] y_q;
    logic       access;
    logic       wr_operands;
    logic       wr_cmd;
    logic       rd_result;
    logic       rd_status;
    logic       bad_addr;
    logic       op_ok;

    // Decode happens in the access phase and setup cycles do nothing here
    assign access      = psel && penable;
    assign wr_operands = access && pwrite && (paddr == REG_OPERANDS);
    assign wr_cmd      = access && pwrite && (paddr == REG_CMD);
    assign rd_result   = access && !pwrite && (paddr == REG_RESULT);
    assign rd_status   = access && !pwrite && (paddr == REG_STATUS);

    // Wrong direction on a known register counts as an unknown address too
    assign bad_addr = access && !(wr_operands || wr_cmd || rd_result || rd_status);

    assign op_ok = op_implemented(pwdata[4:0]);

    // Back-pressure only applies to a command that would actually be queued
    assign pready  = !(wr_cmd && op_ok && full);
    assign pslverr = (wr_cmd && !op_ok) || bad_addr;

    // The FIFO takes the command on the edge where the write completes
    assign push = wr_cmd && op_ok && !full;

    // Reads never wait, so this is high for exactly one cycle per read
    assign res_take = rd_result && res_valid;

    // Staged operands are combined with the command word at push time
    always_comb begin
        push_cmd.op           = alu_op_e'(pwdata[4:0]);
        push_cmd.x            = x_q;
        push_cmd.y            = y_q;
        push_cmd.force_passx  = pwdata[8];
        push_cmd.force_x_zero = pwdata[9];
        push_cmd.cin_n        = pwdata[10];
    end

    always_ff @(posedge clk) begin
        if (wr_operands) begin
            x_q <= pwdata[7:0];
            y_q <= pwdata[15:8];
        end
    end

    // Anything that is not a valid read returns zero
    always_comb begin
        prdata = 32'h0000_0000;
        if (rd_result && res_valid) begin
            prdata = {15'h0000, 1'b1, 7'h00, res.cout_n, res.o};
        end else if (rd_status) begin
            prdata = {22'h00_0000, empty, full, level};
        end
    end

    // An access phase follows either a setup cycle or a stalled access phase
    a_apb_setup_first: assert property (@(posedge clk) disable iff (!arst_n)
        access |-> $past(psel) && ($past(!penable) || $past(!pready)));

endmodule

/* logic/alu_exec.sv */
module alu_exec
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     empty,
    input  alu_cmd_t pop_cmd,
    output logic     pop,
    input  logic     res_take,
    output logic     res_valid,
    output alu_res_t res
);

    exec_state_e state;
    alu_res_t    alu_out;

    // The ALU works directly on the FIFO head since the FIFO falls through
    alu alu0 (
        .cmd (pop_cmd),
        .res (alu_out)
    );

    // Only one result slot, so a new command is taken only when it is free
    assign pop       = (state == EXEC_IDLE) && !empty;
    assign res_valid = (state == EXEC_HOLD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= EXEC_IDLE;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (!empty) begin
                        state <= EXEC_HOLD;
                    end
                end
                EXEC_HOLD: begin
                    // Stay here until the host reads the result out
                    if (res_take) begin
                        state <= EXEC_IDLE;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

    // Result is captured on the same edge that pops its command
    always_ff @(posedge clk) begin
        if (pop) begin
            res <= alu_out;
        end
    end

    // The port only queues implemented opcodes, so exec never pops anything else
    a_pop_implemented: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> op_implemented(pop_cmd.op));

    // A held result must not change before the host has taken it
    a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (res_valid && !res_take) |=> $stable(res));

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    // ALU opcodes, numbered as in the CPU's opcode table
    // Codes missing from this list are not implemented by this unit
    typedef enum logic [4:0] {
        OP_A       = 5'd0,
        OP_B       = 5'd1,
        OP_ZERO    = 5'd2,
        OP_NEG_A   = 5'd3,
        OP_NEG_B   = 5'd4,
        OP_A_INC   = 5'd5,
        OP_B_INC   = 5'd6,
        OP_A_DEC   = 5'd7,
        OP_B_DEC   = 5'd8,
        OP_A_ADD_B = 5'd9,
        OP_A_SUB_B = 5'd10,
        OP_B_SUB_A = 5'd11,
        OP_MUL_HI  = 5'd16,
        OP_MUL_LO  = 5'd17,
        OP_AND     = 5'd25,
        OP_OR      = 5'd26,
        OP_XOR     = 5'd27,
        OP_NOT_A   = 5'd28
    } alu_op_e;

    // One queued command, holding everything the ALU needs for one operation
    typedef struct packed {
        alu_op_e    op;
        logic [7:0] x;
        logic [7:0] y;
        logic       force_passx;
        logic       force_x_zero;
        logic       cin_n;
    } alu_cmd_t;

    // ALU output with its active-low carry
    typedef struct packed {
        logic [7:0] o;
        logic       cout_n;
    } alu_res_t;

    // Exec either waits for a command or holds a result for the host
    typedef enum logic {
        EXEC_IDLE = 1'b0,
        EXEC_HOLD = 1'b1
    } exec_state_e;

    // APB register map
    localparam logic [3:0] REG_OPERANDS = 4'h0;
    localparam logic [3:0] REG_CMD      = 4'h4;
    localparam logic [3:0] REG_RESULT   = 4'h8;
    localparam logic [3:0] REG_STATUS   = 4'hC;

    // True when the code names one of the opcodes above
    function automatic logic op_implemented(logic [4:0] code);
        case (code)
            5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8,
            5'd9, 5'd10, 5'd11, 5'd16, 5'd17, 5'd25, 5'd26, 5'd27, 5'd28:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage

/* logic/alu_top.sv */
module alu_top
    import alu_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    logic [7:0] level;
    alu_cmd_t   push_cmd;
    alu_cmd_t   pop_cmd;
    logic       res_valid;
    logic       res_take;
    alu_res_t   res;

    // The bus side turns APB writes into queued commands and serves reads
    alu_cmd_port port0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .full      (full),
        .empty     (empty),
        .level     (level),
        .push      (push),
        .push_cmd  (push_cmd),
        .res_valid (res_valid),
        .res       (res),
        .res_take  (res_take)
    );

    // Command queue between the bus and the execution stage
    alu_cmd_fifo #(
        .fifo_depth (fifo_depth)
    ) fifo0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_cmd (push_cmd),
        .pop      (pop),
        .pop_cmd  (pop_cmd),
        .full     (full),
        .empty    (empty),
        .level    (level)
    );

    alu_exec exec0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (empty),
        .pop_cmd   (pop_cmd),
        .pop       (pop),
        .res_take  (res_take),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
        -f verilog.f --Mdir obj_dir -o alu_tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run only counts as passed when the testbench printed its pass line
if grep -q "Simulation finished: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

/* verilog.f */
logic/alu_pkg.sv
logic/alu.sv
logic/alu_cmd_fifo.sv
logic/alu_exec.sv
logic/alu_cmd_port.sv
logic/alu_top.sv
bench/alu_tb.sv
